// ==== verilog/fixed_pkg.sv ====
package fixed_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Fixed-point format
  ////////////////////////////////////////////////////////////////////////////

  // Signed Q16.16 in 32 bits
  typedef logic signed [31:0] fixed_t;

  // Saturation limits of fixed_t
  localparam fixed_t FIXED_MAX = 32'sh7fff_ffff;
  localparam fixed_t FIXED_MIN = 32'sh8000_0000;

  ////////////////////////////////////////////////////////////////////////////
  // Job control
  ////////////////////////////////////////////////////////////////////////////

  // Operation code of a job
  typedef enum logic {
    FIXED_ADD = 1'b0,
    FIXED_SUB = 1'b1
  } fixed_op_e;

  // Nonzero vector length in elements
  typedef logic [15:0] length_t;

  ////////////////////////////////////////////////////////////////////////////
  // Result payload
  ////////////////////////////////////////////////////////////////////////////

  // Overflow set when the true result was clipped
  typedef struct packed {
    logic   overflow;
    fixed_t value;
  } fixed_result_t;

endpackage

// ==== verilog/scalar_fixed_adder.sv ====
module scalar_fixed_adder
  import fixed_pkg::*;
(
  input  logic          CLK,
  input  logic          RST,

  // Control
  input  logic          START,
  input  fixed_op_e     OPERATION,
  output logic          READY,

  // Data
  input  fixed_t        DATA_A_IN,
  input  fixed_t        DATA_B_IN,
  output fixed_result_t DATA_OUT
);

  ////////////////////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////////////////////

  // One guard bit above the sign
  logic signed [32:0] a_wide;
  logic signed [32:0] b_wide;
  logic signed [32:0] sum_wide;

  logic               sat_pos;
  logic               sat_neg;
  fixed_result_t      result_next;

  ////////////////////////////////////////////////////////////////////////////
  // Arithmetic
  ////////////////////////////////////////////////////////////////////////////

  assign a_wide = {DATA_A_IN[31], DATA_A_IN};
  assign b_wide = {DATA_B_IN[31], DATA_B_IN};

  // Add or subtract in 33 bits without wrap
  assign sum_wide = (OPERATION == FIXED_SUB) ? (a_wide - b_wide) : (a_wide + b_wide);

  // Guard and sign disagree on overflow
  assign sat_pos = ~sum_wide[32] & sum_wide[31];
  assign sat_neg = sum_wide[32] & ~sum_wide[31];

  always_comb begin
    result_next.overflow = sat_pos | sat_neg;
    if (sat_pos) begin
      result_next.value = FIXED_MAX;
    end else if (sat_neg) begin
      result_next.value = FIXED_MIN;
    end else begin
      result_next.value = sum_wide[31:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////////////////////////////////////////

  // Single-cycle READY one cycle after START
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      READY <= 1'b0;
    end else begin
      READY <= START;
    end
  end

  // Result held until the next START
  always_ff @(posedge CLK) begin
    if (START) begin
      DATA_OUT <= result_next;
    end
  end

endmodule

// ==== verilog/stream_fifo.sv ====
module stream_fifo #(
  parameter int unsigned DEPTH     = 4,
  parameter type         payload_t = logic [31:0]
) (
  input  logic     CLK,
  input  logic     RST,

  // Write side
  input  logic     PUSH,
  input  payload_t PUSH_DATA,
  output logic     FULL,

  // Read side
  input  logic     POP,
  output payload_t POP_DATA,
  output logic     EMPTY
);

  ////////////////////////////////////////////////////////////////////////////
  // Parameters and signals
  ////////////////////////////////////////////////////////////////////////////

  // DEPTH is a power of two of at least 2
  localparam int unsigned ADDR_W = $clog2(DEPTH);

  // Storage
  payload_t          mem [DEPTH];

  // Extra MSB tells full from empty
  logic [ADDR_W:0]   wr_ptr;
  logic [ADDR_W:0]   rd_ptr;

  logic              push_en;
  logic              pop_en;

  ////////////////////////////////////////////////////////////////////////////
  // Status
  ////////////////////////////////////////////////////////////////////////////

  assign EMPTY = (wr_ptr == rd_ptr);
  assign FULL  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                 (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

  // Pop only with data present
  assign pop_en  = POP && !EMPTY;

  // Full but popped in the same cycle still takes the write
  assign push_en = PUSH && (!FULL || pop_en);

  ////////////////////////////////////////////////////////////////////////////
  // Pointers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (push_en) begin
      mem[wr_ptr[ADDR_W-1:0]] <= PUSH_DATA;
    end
  end

  // Head entry valid while not empty
  assign POP_DATA = mem[rd_ptr[ADDR_W-1:0]];

endmodule

// ==== verilog/vector_fixed_adder.sv ====
module vector_fixed_adder
  import fixed_pkg::*;
(
  input  logic          CLK,
  input  logic          RST,

  // Job control
  input  logic          START,
  input  fixed_op_e     OPERATION,
  input  length_t       SIZE_IN,
  output logic          BUSY,
  output logic          DONE,

  // Operand FIFO heads
  input  logic          A_EMPTY,
  input  logic          B_EMPTY,
  input  fixed_t        A_DATA,
  input  fixed_t        B_DATA,
  output logic          OPERAND_POP,

  // Result FIFO write side
  input  logic          RESULT_FULL,
  output logic          RESULT_PUSH,
  output fixed_result_t RESULT_DATA
);

  ////////////////////////////////////////////////////////////////////////////
  // Types and signals
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    FETCH   = 2'd1,
    COMPUTE = 2'd2,
    STORE   = 2'd3
  } seq_state_e;

  seq_state_e    state;

  // Job parameters latched at START
  length_t       length_q;
  fixed_op_e     operation_q;

  // Index of the element in the adder
  length_t       index_q;
  logic          last_element;

  // Scalar adder hookup
  logic          adder_start;
  logic          adder_ready;
  fixed_result_t adder_result;

  ////////////////////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////////////////////

  assign BUSY = (state != IDLE);

  // Both heads popped together
  assign OPERAND_POP = (state == FETCH) && !A_EMPTY && !B_EMPTY;

  // Pair goes into the adder the cycle it leaves the FIFOs
  assign adder_start = OPERAND_POP;

  assign last_element = (index_q == (length_q - length_t'(1)));

  // Push held off by a full result FIFO
  assign RESULT_PUSH = (state == STORE) && !RESULT_FULL;
  assign RESULT_DATA = adder_result;

  // Job end marked with the final push
  assign DONE = RESULT_PUSH && last_element;

  ////////////////////////////////////////////////////////////////////////////
  // Job FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state       <= IDLE;
      length_q    <= '0;
      operation_q <= FIXED_ADD;
      index_q     <= '0;
    end else begin
      case (state)
        IDLE: begin
          // New job only from IDLE
          if (START) begin
            length_q    <= SIZE_IN;
            operation_q <= OPERATION;
            index_q     <= '0;
            state       <= FETCH;
          end
        end
        FETCH: begin
          if (OPERAND_POP) begin
            state <= COMPUTE;
          end
        end
        COMPUTE: begin
          // Result registered in the adder
          if (adder_ready) begin
            state <= STORE;
          end
        end
        STORE: begin
          if (RESULT_PUSH) begin
            if (last_element) begin
              state <= IDLE;
            end else begin
              index_q <= index_q + length_t'(1);
              state   <= FETCH;
            end
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Scalar adder
  ////////////////////////////////////////////////////////////////////////////

  scalar_fixed_adder i_scalar_fixed_adder (
    .CLK      (CLK),
    .RST      (RST),
    .START    (adder_start),
    .OPERATION(operation_q),
    .READY    (adder_ready),
    .DATA_A_IN(A_DATA),
    .DATA_B_IN(B_DATA),
    .DATA_OUT (adder_result)
  );

endmodule

// ==== verilog/vector_adder_top.sv ====
module vector_adder_top
  import fixed_pkg::*;
#(
  parameter int unsigned OPERAND_DEPTH = 4,
  parameter int unsigned RESULT_DEPTH  = 4
) (
  input  logic      CLK,
  input  logic      RST,

  // Job control
  input  logic      START,
  input  fixed_op_e OPERATION,
  input  length_t   SIZE_IN,
  output logic      BUSY,
  output logic      DONE,

  // Operand A stream
  input  logic      A_VALID,
  input  fixed_t    A_DATA,
  output logic      A_READY,

  // Operand B stream
  input  logic      B_VALID,
  input  fixed_t    B_DATA,
  output logic      B_READY,

  // Result stream
  output logic      OUT_VALID,
  output fixed_t    OUT_DATA,
  output logic      OUT_OVERFLOW,
  input  logic      OUT_READY
);

  ////////////////////////////////////////////////////////////////////////////
  // Wires
  ////////////////////////////////////////////////////////////////////////////

  logic          a_full;
  logic          a_empty;
  fixed_t        a_head;

  logic          b_full;
  logic          b_empty;
  fixed_t        b_head;

  logic          operand_pop;

  logic          result_full;
  logic          result_empty;
  logic          result_push;
  fixed_result_t result_data;
  fixed_result_t result_head;

  // Ready means room and valid means data
  assign A_READY   = ~a_full;
  assign B_READY   = ~b_full;
  assign OUT_VALID = ~result_empty;

  assign OUT_DATA     = result_head.value;
  assign OUT_OVERFLOW = result_head.overflow;

  ////////////////////////////////////////////////////////////////////////////
  // Operand FIFOs
  ////////////////////////////////////////////////////////////////////////////

  stream_fifo #(
    .DEPTH    (OPERAND_DEPTH),
    .payload_t(fixed_t)
  ) a_fifo (
    .CLK(CLK), .RST(RST),
    .PUSH(A_VALID), .PUSH_DATA(A_DATA), .FULL(a_full),
    .POP(operand_pop), .POP_DATA(a_head), .EMPTY(a_empty)
  );

  stream_fifo #(
    .DEPTH    (OPERAND_DEPTH),
    .payload_t(fixed_t)
  ) b_fifo (
    .CLK(CLK), .RST(RST),
    .PUSH(B_VALID), .PUSH_DATA(B_DATA), .FULL(b_full),
    .POP(operand_pop), .POP_DATA(b_head), .EMPTY(b_empty)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer and result FIFO
  ////////////////////////////////////////////////////////////////////////////

  vector_fixed_adder i_vector_fixed_adder (
    .CLK(CLK), .RST(RST),
    .START(START), .OPERATION(OPERATION), .SIZE_IN(SIZE_IN),
    .BUSY(BUSY), .DONE(DONE),
    .A_EMPTY(a_empty), .B_EMPTY(b_empty),
    .A_DATA(a_head), .B_DATA(b_head), .OPERAND_POP(operand_pop),
    .RESULT_FULL(result_full), .RESULT_PUSH(result_push),
    .RESULT_DATA(result_data)
  );

  // Pops on each accepted output beat
  stream_fifo #(
    .DEPTH    (RESULT_DEPTH),
    .payload_t(fixed_result_t)
  ) result_fifo (
    .CLK(CLK), .RST(RST),
    .PUSH(result_push), .PUSH_DATA(result_data), .FULL(result_full),
    .POP(OUT_READY), .POP_DATA(result_head), .EMPTY(result_empty)
  );

endmodule

// ==== tests/vector_adder_assert.sv ====
module vector_adder_assert (
  input logic CLK,
  input logic RST,
  input logic DONE,
  input logic A_EMPTY,
  input logic B_EMPTY,
  input logic OPERAND_POP,
  input logic RESULT_FULL,
  input logic RESULT_PUSH
);

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////////////////////////////////////////
  // Sequencer handshake properties
  ////////////////////////////////////////////////////////////////////////////

  // Count of failed properties
  int unsigned failures = 0;

  // No push into a full result FIFO
  push_has_room: assert property (@(posedge CLK) disable iff (RST)
    RESULT_PUSH |-> !RESULT_FULL)
    else begin
      $error("result pushed while the result FIFO is full");
      failures++;
    end

  // Single-cycle job end
  done_one_cycle: assert property (@(posedge CLK) disable iff (RST)
    DONE |=> !DONE)
    else begin
      $error("DONE high for more than one cycle");
      failures++;
    end

  // Pair popped only with both heads present
  pop_with_data: assert property (@(posedge CLK) disable iff (RST)
    OPERAND_POP |-> (!A_EMPTY && !B_EMPTY))
    else begin
      $error("operands popped from an empty FIFO");
      failures++;
    end

endmodule

bind vector_fixed_adder vector_adder_assert i_assert (
  .CLK(CLK), .RST(RST), .DONE(DONE),
  .A_EMPTY(A_EMPTY), .B_EMPTY(B_EMPTY), .OPERAND_POP(OPERAND_POP),
  .RESULT_FULL(RESULT_FULL), .RESULT_PUSH(RESULT_PUSH)
);

// ==== tests/vector_adder_tb.sv ====
module vector_adder_tb
  import fixed_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////////////////////////////////////////
  // Parameters and signals
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned OPERAND_DEPTH = 4;
  localparam int unsigned RESULT_DEPTH  = 4;
  localparam int unsigned TRACE_WORDS   = 64;
  localparam int unsigned WAIT_LIMIT    = 2000;
  localparam logic [31:0] SEED          = 32'he7d4_98f2;

  logic      CLK;
  logic      RST;
  logic      START;
  fixed_op_e OPERATION;
  length_t   SIZE_IN;
  logic      BUSY;
  logic      DONE;
  logic      A_VALID;
  fixed_t    A_DATA;
  logic      A_READY;
  logic      B_VALID;
  fixed_t    B_DATA;
  logic      B_READY;
  logic      OUT_VALID;
  fixed_t    OUT_DATA;
  logic      OUT_OVERFLOW;
  logic      OUT_READY;

  // Trace word of a tag, three 32-bit fields and one 4-bit field
  logic [103:0]  trace_mem [TRACE_WORDS];

  // Jobs and elements as read from the trace
  fixed_op_e     job_op [$];
  length_t       job_len [$];
  logic [31:0]   job_mask [$];
  logic          job_bp [$];
  int            job_first [$];
  fixed_t        elem_a [$];
  fixed_t        elem_b [$];
  fixed_result_t elem_exp [$];

  logic [31:0]   a_rng;
  logic [31:0]   b_rng;
  int            done_count;
  logic          ready_dropped;

  ////////////////////////////////////////////////////////////////////////////
  // DUT, clock and monitor
  ////////////////////////////////////////////////////////////////////////////

  vector_adder_top #(
    .OPERAND_DEPTH(OPERAND_DEPTH),
    .RESULT_DEPTH (RESULT_DEPTH)
  ) i_dut (
    .CLK(CLK), .RST(RST),
    .START(START), .OPERATION(OPERATION), .SIZE_IN(SIZE_IN),
    .BUSY(BUSY), .DONE(DONE),
    .A_VALID(A_VALID), .A_DATA(A_DATA), .A_READY(A_READY),
    .B_VALID(B_VALID), .B_DATA(B_DATA), .B_READY(B_READY),
    .OUT_VALID(OUT_VALID), .OUT_DATA(OUT_DATA), .OUT_OVERFLOW(OUT_OVERFLOW),
    .OUT_READY(OUT_READY)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // DONE and ready are stable at the falling edge
  always @(negedge CLK) begin
    if (!RST) begin
      if (DONE) begin
        done_count++;
      end
      if (!A_READY || !B_READY) begin
        ready_dropped = 1'b1;
      end
      if (i_dut.i_vector_fixed_adder.i_assert.failures != 0) begin
        fail_run("sequencer assertion failed");
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers and checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_result(input int index, input fixed_result_t expected,
                              input fixed_result_t actual);
    if (actual !== expected) begin
      fail_run($sformatf(
        "[FAIL] %0t ns OUT_DATA/OUT_OVERFLOW element %0d: expected %h/%0b, got %h/%0b",
        $time, index, expected.value, expected.overflow, actual.value, actual.overflow));
    end
  endtask

  task automatic check_done(input int expected, input int actual);
    if (actual != expected) begin
      fail_run($sformatf("[FAIL] %0t ns DONE count: expected %0d, got %0d",
                         $time, expected, actual));
    end
  endtask

  task automatic load_trace();
    logic [103:0]  word;
    fixed_result_t exp;
    int            i;
    logic          reading;
    $readmemh("tests/vector_adder_trace.txt", trace_mem);
    i = 0;
    reading = 1'b1;
    while (reading) begin
      if (i >= TRACE_WORDS) fail_run("trace file has no end record");
      word = trace_mem[i];
      case (word[103:100])
        4'h1: begin
          job_op.push_back(fixed_op_e'(word[68]));
          job_len.push_back(word[51:36]);
          job_mask.push_back(word[35:4]);
          job_bp.push_back(word[0]);
          job_first.push_back(elem_a.size());
        end
        4'h2: begin
          exp.value    = word[35:4];
          exp.overflow = word[0];
          elem_a.push_back(word[99:68]);
          elem_b.push_back(word[67:36]);
          elem_exp.push_back(exp);
        end
        4'hf: reading = 1'b0;
        default: fail_run($sformatf("trace word %0d is no job, element or end record", i));
      endcase
      i++;
    end
  endtask

  task automatic wait_idle();
    int unsigned cycles;
    cycles = 0;
    while (BUSY) begin
      @(negedge CLK);
      cycles++;
      if (cycles > WAIT_LIMIT) fail_run("timeout while waiting for BUSY to fall");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stream drivers
  ////////////////////////////////////////////////////////////////////////////

  // Valid raised only with ready high so each beat transfers
  task automatic feed_a(input int first, input int count);
    int unsigned cycles;
    int          i;
    for (i = 0; i < count; i++) begin
      a_rng = xorshift32(a_rng);
      repeat (a_rng % 3) @(negedge CLK);
      cycles = 0;
      while (!A_READY) begin
        @(negedge CLK);
        cycles++;
        if (cycles > WAIT_LIMIT) fail_run("timeout while waiting for A_READY");
      end
      A_VALID = 1'b1;
      A_DATA  = elem_a[first + i];
      @(negedge CLK);
      A_VALID = 1'b0;
    end
  endtask

  // B runs at its own rate
  task automatic feed_b(input int first, input int count);
    int unsigned cycles;
    int          i;
    for (i = 0; i < count; i++) begin
      b_rng = xorshift32(b_rng);
      repeat (b_rng % 2) @(negedge CLK);
      cycles = 0;
      while (!B_READY) begin
        @(negedge CLK);
        cycles++;
        if (cycles > WAIT_LIMIT) fail_run("timeout while waiting for B_READY");
      end
      B_VALID = 1'b1;
      B_DATA  = elem_b[first + i];
      @(negedge CLK);
      B_VALID = 1'b0;
    end
  endtask

  // Mask bit set means stall in that cycle of 32
  task automatic collect_results(input int first, input int count, input logic [31:0] mask);
    fixed_result_t actual;
    int unsigned   k;
    int unsigned   cycles;
    int            got;
    k = 0;
    got = 0;
    cycles = 0;
    while (got < count) begin
      OUT_READY = !mask[k % 32];
      if (OUT_VALID && OUT_READY) begin
        actual.value    = OUT_DATA;
        actual.overflow = OUT_OVERFLOW;
        check_result(first + got, elem_exp[first + got], actual);
        got++;
        cycles = 0;
      end
      @(negedge CLK);
      k++;
      cycles++;
      if (cycles > WAIT_LIMIT) fail_run("timeout while waiting for a result");
    end
    OUT_READY = 1'b0;
  endtask

  task automatic run_job(input int j, input int first, input int count);
    wait_idle();
    ready_dropped = 1'b0;
    START     = 1'b1;
    OPERATION = job_op[j];
    SIZE_IN   = job_len[j];
    @(negedge CLK);
    if (!BUSY) fail_run("BUSY did not rise after START");
    // Second START while busy with another op and length
    OPERATION = (job_op[j] == FIXED_ADD) ? FIXED_SUB : FIXED_ADD;
    SIZE_IN   = job_len[j] + length_t'(3);
    @(negedge CLK);
    START = 1'b0;
    fork
      feed_a(first, count);
      feed_b(first, count);
      collect_results(first, count, job_mask[j]);
    join
    wait_idle();
    check_done(j + 1, done_count);
    if (OUT_VALID) fail_run("result stream holds an extra result after the job");
    if (job_bp[j] && !ready_dropped) fail_run("A_READY and B_READY stayed high under stall");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int j;
    int first;
    int count;
    RST       = 1'b1;
    START     = 1'b0;
    OPERATION = FIXED_ADD;
    SIZE_IN   = '0;
    A_VALID   = 1'b0;
    A_DATA    = '0;
    B_VALID   = 1'b0;
    B_DATA    = '0;
    OUT_READY = 1'b0;
    a_rng      = SEED;
    b_rng      = xorshift32(SEED);
    done_count = 0;
    ready_dropped = 1'b0;
    load_trace();
    repeat (4) @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);
    if (!A_READY || !B_READY || OUT_VALID || DONE || BUSY) begin
      fail_run("outputs not at their reset values after reset");
    end
    for (j = 0; j < job_len.size(); j++) begin
      first = job_first[j];
      count = ((j + 1 < job_first.size()) ? job_first[j + 1] : elem_a.size()) - first;
      if (count != int'(job_len[j])) begin
        fail_run($sformatf("trace job %0d lists %0d elements for length %0d",
                           j, count, job_len[j]));
      end
      run_job(j, first, count);
    end
    if (i_dut.i_vector_fixed_adder.i_assert.failures == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      fail_run("sequencer assertions failed during the run");
    end
  end

endmodule

// ==== tests/vector_adder_trace.txt ====
// tag 1 job:  1_<op>_<length>_<stall mask, bit set stalls OUT_READY>_<expect ready drop>
// tag 2 elem: 2_<A>_<B>_<expected value>_<expected overflow>, tag f ends the trace
1_00000000_00000001_00000000_0
2_00010000_00008000_00018000_0
1_00000001_00000001_00000000_0
2_00010000_00030000_fffe0000_0
1_00000000_00000008_00000000_0
2_7fff0000_00020000_7fffffff_1
2_12345678_01010101_13355779_0
2_80000000_ffffffff_80000000_1
2_fff00000_00080000_fff80000_0
2_40000000_40000000_7fffffff_1
2_7fffffff_00000000_7fffffff_0
2_c0000000_c0000000_80000000_0
2_00000001_ffffffff_00000000_0
1_00000001_00000008_92492492_0
2_80000000_00000001_80000000_1
2_7fffffff_ffffffff_7fffffff_1
2_00050000_00028000_00028000_0
2_00000000_80000000_7fffffff_1
2_ffff0000_ffff0000_00000000_0
2_80000000_80000000_00000000_0
2_3fffffff_c0000000_7fffffff_0
2_12340000_56780000_bbbc0000_0
1_00000000_0000000c_fffffffe_1
2_00010000_00000100_00010100_0
2_00020000_00000200_00020200_0
2_00030000_00000300_00030300_0
2_00040000_00000400_00040400_0
2_00050000_00000500_00050500_0
2_00060000_00000600_00060600_0
2_00070000_00000700_00070700_0
2_00080000_00000800_00080800_0
2_00090000_00000900_00090900_0
2_000a0000_00000a00_000a0a00_0
2_000b0000_00000b00_000b0b00_0
2_000c0000_00000c00_000c0c00_0
f_00000000_00000000_00000000_0

// ==== project.f ====
verilog/fixed_pkg.sv
verilog/scalar_fixed_adder.sv
verilog/stream_fifo.sv
verilog/vector_fixed_adder.sv
verilog/vector_adder_top.sv
tests/vector_adder_assert.sv
tests/vector_adder_tb.sv

// ==== Bender.yml ====
package:
  name: vector_adder

sources:
  # RTL in compile order
  - files:
      - verilog/fixed_pkg.sv
      - verilog/scalar_fixed_adder.sv
      - verilog/stream_fifo.sv
      - verilog/vector_fixed_adder.sv
      - verilog/vector_adder_top.sv

  # Simulation only
  - target: test
    files:
      - tests/vector_adder_assert.sv
      - tests/vector_adder_tb.sv
